// File: logic/hdc_pkg.sv
package hdc_pkg;

    // default hypervector width in bits
    parameter int HV_WIDTH_DEF = 32;

    // default item address width, 2**10 = 1024 items in the item memory
    parameter int ADDR_WIDTH_DEF = 10;

    // default number of hypervector pairs buffered between fetch and encode
    parameter int FIFO_DEPTH_DEF = 4;

    // encoder FSM
    // ENC_ACCUM pops the FIFO and folds each entry into the accumulators
    // ENC_HOLD presents a finished window and waits for the host to take it
    typedef enum logic {
        ENC_ACCUM,
        ENC_HOLD
    } enc_state_t;

endpackage

// File: logic/hv_stream_if.sv
interface hv_stream_if #(
    parameter int HV_WIDTH = hdc_pkg::HV_WIDTH_DEF
);

    // strobes and levels
    logic push;
    logic pop;
    logic full;
    logic empty;

    // payload travels on nets because the FIFO reads it on the write bus
    // and drives it on the read bus through the same modport
    wire [HV_WIDTH-1:0] hv_a;
    wire [HV_WIDTH-1:0] hv_b;
    wire                last;

    modport writer (
        output push, hv_a, hv_b, last,
        input  full
    );

    modport store (
        input  push, pop,
        inout  hv_a, hv_b, last,
        output full, empty
    );

    modport reader (
        output pop,
        input  hv_a, hv_b, last, empty
    );

endinterface

// File: logic/item_fetch.sv
module item_fetch #(
    parameter int HV_WIDTH   = hdc_pkg::HV_WIDTH_DEF,
    parameter int ADDR_WIDTH = hdc_pkg::ADDR_WIDTH_DEF
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  load,
    input  logic [ADDR_WIDTH-1:0] load_addr,
    input  logic [HV_WIDTH-1:0]   load_data,
    input  logic                  sym_valid,
    input  logic [ADDR_WIDTH-1:0] sym_addr_a,
    input  logic [ADDR_WIDTH-1:0] sym_addr_b,
    input  logic                  sym_last,
    hv_stream_if.writer           out
);

    localparam int NUM_ITEMS = 2 ** ADDR_WIDTH;

    logic [HV_WIDTH-1:0] item_mem [NUM_ITEMS];

    // first stage holds the accepted symbol
    logic                  sym_q;
    logic [ADDR_WIDTH-1:0] addr_a_q;
    logic [ADDR_WIDTH-1:0] addr_b_q;
    logic                  last_q;

    // second stage holds the two item hypervectors being pushed
    logic                  push_q;
    logic [HV_WIDTH-1:0]   hv_a_q;
    logic [HV_WIDTH-1:0]   hv_b_q;
    logic                  push_last_q;

    // host writes land at the edge that samples load, so a symbol
    // strobed one cycle later reads the new value at its own read edge
    always_ff @(posedge clk) begin
        if (load) begin
            item_mem[load_addr] <= load_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            sym_q  <= 1'b0;
            push_q <= 1'b0;
        end else begin
            sym_q  <= sym_valid;
            push_q <= sym_q;
        end
    end

    always_ff @(posedge clk) begin
        if (sym_valid) begin
            addr_a_q <= sym_addr_a;
            addr_b_q <= sym_addr_b;
            last_q   <= sym_last;
        end
    end

    // one read port per lane, both registered
    always_ff @(posedge clk) begin
        if (sym_q) begin
            hv_a_q      <= item_mem[addr_a_q];
            hv_b_q      <= item_mem[addr_b_q];
            push_last_q <= last_q;
        end
    end

    assign out.push = push_q;
    assign out.hv_a = hv_a_q;
    assign out.hv_b = hv_b_q;
    assign out.last = push_last_q;

    // the FIFO full level already accounts for both symbols in flight here
    no_sym_when_full: assert property (
        @(posedge clk) disable iff (reset) sym_valid |-> !out.full
    );

    // a load and a symbol in the same cycle would race on the item memory
    no_load_with_sym: assert property (
        @(posedge clk) disable iff (reset) !(load && sym_valid)
    );

endmodule

// File: logic/hv_fifo.sv
module hv_fifo #(
    parameter int HV_WIDTH   = hdc_pkg::HV_WIDTH_DEF,
    parameter int FIFO_DEPTH = hdc_pkg::FIFO_DEPTH_DEF
) (
    input  logic        clk,
    input  logic        reset,
    hv_stream_if.store  wr,
    hv_stream_if.store  rd
);

    localparam int PTR_W   = $clog2(FIFO_DEPTH);
    localparam int CNT_W   = $clog2(FIFO_DEPTH + 1);
    localparam int USED_W  = CNT_W + 1;
    localparam int ENTRY_W = 2 * HV_WIDTH + 1;

    // each entry is {hv_a, hv_b, last}
    logic [ENTRY_W-1:0] entries [FIFO_DEPTH];

    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic [USED_W-1:0]  used;
    logic [ENTRY_W-1:0] head;
    logic               empty;
    logic               full;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + PTR_W'(1);
    endfunction

    always_ff @(posedge clk) begin
        if (wr.push) begin
            entries[wr_ptr] <= {wr.hv_a, wr.hv_b, wr.last};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr.push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (rd.pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({wr.push, rd.pop})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;
            endcase
        end
    end

    // the head is shown straight from storage so a pop takes it in the same cycle
    assign head = entries[rd_ptr];
    assign {rd.hv_a, rd.hv_b, rd.last} = head;

    // the push in progress counts as taken, and one more slot stays free for
    // the symbol still sitting in the fetch address register
    assign used  = USED_W'(count) + USED_W'(wr.push);
    assign full  = used > USED_W'(FIFO_DEPTH - 2);
    assign empty = (count == '0);

    assign wr.full  = full;
    assign wr.empty = empty;
    assign rd.full  = full;
    assign rd.empty = empty;

    no_overflow: assert property (
        @(posedge clk) disable iff (reset)
        wr.push |-> (count != CNT_W'(FIFO_DEPTH)) || rd.pop
    );

    no_underflow: assert property (
        @(posedge clk) disable iff (reset) rd.pop |-> !empty
    );

endmodule

// File: logic/ngram_encoder.sv
module ngram_encoder #(
    parameter int HV_WIDTH = hdc_pkg::HV_WIDTH_DEF
) (
    input  logic                clk,
    input  logic                reset,
    hv_stream_if.reader         in,
    input  logic                result_ack,
    output logic                result_valid,
    output logic [HV_WIDTH-1:0] result_a,
    output logic [HV_WIDTH-1:0] result_b
);

    import hdc_pkg::*;

    localparam int POS_W = $clog2(HV_WIDTH);

    enc_state_t          state;
    logic [POS_W-1:0]    pos;
    logic [HV_WIDTH-1:0] acc_a;
    logic [HV_WIDTH-1:0] acc_b;
    logic                take;
    logic                pos_wrap;

    // rotate right by n, a shift by the full width gives zero so n = 0 is plain v
    function automatic logic [HV_WIDTH-1:0] rotr(
        input logic [HV_WIDTH-1:0] v,
        input logic [POS_W-1:0]    n
    );
        return (v >> n) | (v << (HV_WIDTH - int'(n)));
    endfunction

    assign take     = (state == ENC_ACCUM) && !in.empty;
    assign pos_wrap = (pos == POS_W'(HV_WIDTH - 1));
    assign in.pop   = take;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ENC_ACCUM;
            pos   <= '0;
            acc_a <= '0;
            acc_b <= '0;
        end else begin
            case (state)
                ENC_ACCUM: begin
                    if (take) begin
                        acc_a <= acc_a ^ rotr(in.hv_a, pos);
                        acc_b <= acc_b ^ rotr(in.hv_b, pos);
                        if (in.last || pos_wrap) begin
                            pos <= '0;
                        end else begin
                            pos <= pos + POS_W'(1);
                        end
                        // the final symbol of a window closes it at this edge
                        if (in.last) begin
                            state <= ENC_HOLD;
                        end
                    end
                end
                ENC_HOLD: begin
                    // nothing is popped while the host has not taken the result
                    if (result_ack) begin
                        state <= ENC_ACCUM;
                        acc_a <= '0;
                        acc_b <= '0;
                    end
                end
                default: begin
                    state <= ENC_ACCUM;
                end
            endcase
        end
    end

    assign result_valid = (state == ENC_HOLD);
    assign result_a     = acc_a;
    assign result_b     = acc_b;

    // an ack outside a held result would drop the window being accumulated
    ack_only_when_valid: assert property (
        @(posedge clk) disable iff (reset) result_ack |-> result_valid
    );

endmodule

// File: logic/hdc_encoder_top.sv
module hdc_encoder_top #(
    parameter int HV_WIDTH   = hdc_pkg::HV_WIDTH_DEF,
    parameter int ADDR_WIDTH = hdc_pkg::ADDR_WIDTH_DEF,
    parameter int FIFO_DEPTH = hdc_pkg::FIFO_DEPTH_DEF
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  load,
    input  logic [ADDR_WIDTH-1:0] load_addr,
    input  logic [HV_WIDTH-1:0]   load_data,
    input  logic                  sym_valid,
    input  logic [ADDR_WIDTH-1:0] sym_addr_a,
    input  logic [ADDR_WIDTH-1:0] sym_addr_b,
    input  logic                  sym_last,
    output logic                  sym_full,
    input  logic                  result_ack,
    output logic                  result_valid,
    output logic [HV_WIDTH-1:0]   result_a,
    output logic [HV_WIDTH-1:0]   result_b
);

    import hdc_pkg::*;

    hv_stream_if #(.HV_WIDTH(HV_WIDTH)) fetch_bus ();
    hv_stream_if #(.HV_WIDTH(HV_WIDTH)) enc_bus ();

    // fetch_bus has no reader and enc_bus has no writer
    assign fetch_bus.pop = 1'b0;
    assign enc_bus.push  = 1'b0;

    assign sym_full = fetch_bus.full;

    item_fetch #(
        .HV_WIDTH   (HV_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_fetch (
        .clk        (clk),
        .reset      (reset),
        .load       (load),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .sym_valid  (sym_valid),
        .sym_addr_a (sym_addr_a),
        .sym_addr_b (sym_addr_b),
        .sym_last   (sym_last),
        .out        (fetch_bus.writer)
    );

    hv_fifo #(
        .HV_WIDTH   (HV_WIDTH),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk   (clk),
        .reset (reset),
        .wr    (fetch_bus.store),
        .rd    (enc_bus.store)
    );

    ngram_encoder #(
        .HV_WIDTH (HV_WIDTH)
    ) u_encoder (
        .clk          (clk),
        .reset        (reset),
        .in           (enc_bus.reader),
        .result_ack   (result_ack),
        .result_valid (result_valid),
        .result_a     (result_a),
        .result_b     (result_b)
    );

    // with nothing in flight, a window-closing symbol becomes a held result
    // three edges after the edge that samples it
    idle_window_latency: assert property (
        @(posedge clk) disable iff (reset)
        (sym_valid && sym_last && !$past(sym_valid) && !fetch_bus.push
            && enc_bus.empty && u_encoder.state == ENC_ACCUM)
        |-> ##4 result_valid
    );

endmodule

// File: bench/tb_hdc_encoder.sv
module tb_hdc_encoder;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int HV_WIDTH   = 32;
    localparam int ADDR_WIDTH = 10;
    localparam int FIFO_DEPTH = 4;
    localparam int NUM_ITEMS  = 2 ** ADDR_WIDTH;
    localparam int WAIT_LIMIT = 200;

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  load;
    logic [ADDR_WIDTH-1:0] load_addr;
    logic [HV_WIDTH-1:0]   load_data;
    logic                  sym_valid;
    logic [ADDR_WIDTH-1:0] sym_addr_a;
    logic [ADDR_WIDTH-1:0] sym_addr_b;
    logic                  sym_last;
    logic                  sym_full;
    logic                  result_ack;
    logic                  result_valid;
    logic [HV_WIDTH-1:0]   result_a;
    logic [HV_WIDTH-1:0]   result_b;

    // host copy of the item memory
    logic [HV_WIDTH-1:0] item_shadow [NUM_ITEMS];

    // reference for the open window and a queue of finished windows in the order they close
    logic [HV_WIDTH-1:0] model_a;
    logic [HV_WIDTH-1:0] model_b;
    int                  model_pos;
    logic [HV_WIDTH-1:0] expected_a_q [$];
    logic [HV_WIDTH-1:0] expected_b_q [$];

    int seed;

    always #2 clk = ~clk;

    hdc_encoder_top #(
        .HV_WIDTH   (HV_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) DUT (
        .clk          (clk),
        .reset        (reset),
        .load         (load),
        .load_addr    (load_addr),
        .load_data    (load_data),
        .sym_valid    (sym_valid),
        .sym_addr_a   (sym_addr_a),
        .sym_addr_b   (sym_addr_b),
        .sym_last     (sym_last),
        .sym_full     (sym_full),
        .result_ack   (result_ack),
        .result_valid (result_valid),
        .result_a     (result_a),
        .result_b     (result_b)
    );

    // bit j of the rotated word is bit (j + n) mod width of the input
    function automatic logic [HV_WIDTH-1:0] rotate_right_model(
        input logic [HV_WIDTH-1:0] v,
        input int                  n
    );
        logic [HV_WIDTH-1:0] r;
        for (int j = 0; j < HV_WIDTH; j++) begin
            r[j] = v[(j + n) % HV_WIDTH];
        end
        return r;
    endfunction

    function automatic logic [HV_WIDTH-1:0] random_word();
        logic [31:0] r;
        r = $random(seed);
        return r[HV_WIDTH-1:0];
    endfunction

    function automatic logic [ADDR_WIDTH-1:0] random_addr();
        logic [31:0] r;
        r = $random(seed);
        return r[ADDR_WIDTH-1:0];
    endfunction

    // folds one symbol into the reference and queues the window when it closes
    function automatic void model_symbol(
        input logic [ADDR_WIDTH-1:0] addr_a,
        input logic [ADDR_WIDTH-1:0] addr_b,
        input logic                  last
    );
        model_a = model_a ^ rotate_right_model(item_shadow[addr_a], model_pos % HV_WIDTH);
        model_b = model_b ^ rotate_right_model(item_shadow[addr_b], model_pos % HV_WIDTH);
        model_pos++;
        if (last) begin
            expected_a_q.push_back(model_a);
            expected_b_q.push_back(model_b);
            model_a   = '0;
            model_b   = '0;
            model_pos = 0;
        end
    endfunction

    task automatic check_value(
        input string               test_name,
        input logic [HV_WIDTH-1:0] expected,
        input logic [HV_WIDTH-1:0] actual
    );
        if (actual !== expected) begin
            $display("ERROR %s: expected %h, actual %h", test_name, expected, actual);
            $display("Test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic report_failure(input string text);
        $display("%s", text);
        $display("Test failed");
        $fatal(1, "run stopped");
    endtask

    task automatic wait_sym_room(input string test_name);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (sym_full) begin
            if (cycles == WAIT_LIMIT) begin
                report_failure({test_name, ": sym_full stayed high too long"});
            end
            cycles++;
            @(negedge clk);
        end
    endtask

    task automatic wait_result_valid(input string test_name);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!result_valid) begin
            if (cycles == WAIT_LIMIT) begin
                report_failure({test_name, ": result_valid never rose"});
            end
            cycles++;
            @(negedge clk);
        end
    endtask

    // one strobe cycle then two quiet ones, so that the full level seen
    // before the next strobe already covers this symbol
    task automatic issue_symbol(
        input logic [ADDR_WIDTH-1:0] addr_a,
        input logic [ADDR_WIDTH-1:0] addr_b,
        input logic                  last
    );
        @(posedge clk);
        sym_valid  <= 1'b1;
        sym_addr_a <= addr_a;
        sym_addr_b <= addr_b;
        sym_last   <= last;
        @(posedge clk);
        sym_valid <= 1'b0;
        sym_last  <= 1'b0;
        @(posedge clk);
    endtask

    task automatic add_symbol(
        input string                 test_name,
        input logic [ADDR_WIDTH-1:0] addr_a,
        input logic [ADDR_WIDTH-1:0] addr_b,
        input logic                  last
    );
        wait_sym_room(test_name);
        issue_symbol(addr_a, addr_b, last);
        model_symbol(addr_a, addr_b, last);
    endtask

    task automatic check_next_result(input string test_name);
        logic [HV_WIDTH-1:0] exp_a;
        logic [HV_WIDTH-1:0] exp_b;
        if (expected_a_q.size() == 0) begin
            report_failure({test_name, ": no finished window to compare against"});
        end
        wait_result_valid(test_name);
        exp_a = expected_a_q.pop_front();
        exp_b = expected_b_q.pop_front();
        check_value({test_name, " lane a"}, exp_a, result_a);
        check_value({test_name, " lane b"}, exp_b, result_b);
    endtask

    task automatic ack_result();
        @(posedge clk);
        result_ack <= 1'b1;
        @(posedge clk);
        result_ack <= 1'b0;
    endtask

    task automatic load_item(input logic [ADDR_WIDTH-1:0] addr, input logic [HV_WIDTH-1:0] data);
        @(posedge clk);
        load      <= 1'b1;
        load_addr <= addr;
        load_data <= data;
        item_shadow[addr] = data;
        @(posedge clk);
        load <= 1'b0;
    endtask

    task automatic fill_items();
        logic [HV_WIDTH-1:0] data;
        for (int a = 0; a < NUM_ITEMS; a++) begin
            data = random_word();
            @(posedge clk);
            load      <= 1'b1;
            load_addr <= ADDR_WIDTH'(a);
            load_data <= data;
            item_shadow[a] = data;
        end
        @(posedge clk);
        load <= 1'b0;
    endtask

    task automatic send_random_window(input string test_name, input int length);
        for (int i = 0; i < length; i++) begin
            add_symbol(test_name, random_addr(), random_addr(), i == length - 1);
        end
    endtask

    task automatic test_single_symbol();
        add_symbol("single_symbol", random_addr(), random_addr(), 1'b1);
        check_next_result("single_symbol");
        ack_result();
    endtask

    task automatic test_short_window();
        send_random_window("short_window", 5);
        check_next_result("short_window");
        ack_result();
    endtask

    task automatic test_long_window();
        send_random_window("long_window", 40);
        check_next_result("long_window");
        ack_result();
    endtask

    task automatic test_back_pressure();
        logic [ADDR_WIDTH-1:0] win_a [10];
        logic [ADDR_WIDTH-1:0] win_b [10];
        int                    sent;
        bit                    saw_full;
        send_random_window("back_pressure", 3);
        // the first result stays held while the next window piles up
        check_next_result("back_pressure held");
        for (int i = 0; i < 10; i++) begin
            win_a[i] = random_addr();
            win_b[i] = random_addr();
        end
        sent     = 0;
        saw_full = 1'b0;
        while (!saw_full && sent < 10) begin
            @(negedge clk);
            if (sym_full) begin
                saw_full = 1'b1;
            end else begin
                issue_symbol(win_a[sent], win_b[sent], sent == 9);
                model_symbol(win_a[sent], win_b[sent], sent == 9);
                sent++;
            end
        end
        if (!saw_full) begin
            report_failure("back_pressure: sym_full did not rise while a result was held");
        end
        // fewer than two free entries remain once the push under way is counted
        check_value("back_pressure full level", HV_WIDTH'(FIFO_DEPTH - 1), HV_WIDTH'(sent));
        ack_result();
        while (sent < 10) begin
            add_symbol("back_pressure", win_a[sent], win_b[sent], sent == 9);
            sent++;
        end
        check_next_result("back_pressure second");
        ack_result();
        send_random_window("back_pressure", 4);
        check_next_result("back_pressure third");
        ack_result();
    endtask

    task automatic test_item_rewrite();
        logic [ADDR_WIDTH-1:0] addr_a;
        logic [ADDR_WIDTH-1:0] addr_b;
        addr_a = random_addr();
        addr_b = random_addr();
        add_symbol("item_rewrite", addr_a, addr_b, 1'b1);
        check_next_result("item_rewrite before");
        ack_result();
        load_item(addr_a, random_word());
        load_item(addr_b, random_word());
        add_symbol("item_rewrite", addr_a, addr_b, 1'b1);
        check_next_result("item_rewrite after");
        ack_result();
        // a longer window reusing the new items starts from clean accumulators too
        add_symbol("item_rewrite", addr_b, addr_a, 1'b0);
        add_symbol("item_rewrite", addr_a, addr_b, 1'b1);
        check_next_result("item_rewrite pair");
        ack_result();
    endtask

    initial begin
        seed       = 32'hd94c21d0;
        reset      = 1'b1;
        load       = 1'b0;
        load_addr  = '0;
        load_data  = '0;
        sym_valid  = 1'b0;
        sym_addr_a = '0;
        sym_addr_b = '0;
        sym_last   = 1'b0;
        result_ack = 1'b0;
        model_a    = '0;
        model_b    = '0;
        model_pos  = 0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        fill_items();
        test_single_symbol();
        test_short_window();
        test_long_window();
        test_back_pressure();
        test_item_rewrite();
        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: sources.f
logic/hdc_pkg.sv
logic/hv_stream_if.sv
logic/item_fetch.sv
logic/hv_fifo.sv
logic/ngram_encoder.sv
logic/hdc_encoder_top.sv
bench/tb_hdc_encoder.sv

// File: Bender.yml
package:
  name: hdc_encoder

sources:
  - logic/hdc_pkg.sv
  - logic/hv_stream_if.sv
  - logic/item_fetch.sv
  - logic/hv_fifo.sv
  - logic/ngram_encoder.sv
  - logic/hdc_encoder_top.sv
  - target: simulation
    files:
      - bench/tb_hdc_encoder.sv
